// ==== hdl/muladd_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "muladd_defs_defs.svh"

module muladd_addr_gen (
   input  wire logic                      clk,
   input  wire logic                      rst,
   muladd_cfg_if.dst                      cfg,
   output logic [`MULADD_ADDR_W-1:0]      addr,
   output logic                           mem_en,
   output logic                           done
);

   typedef enum logic [1:0] {
      st_idle,
      st_delay,
      st_active
   } state_t;

   state_t                     state;
   logic [`MULADD_PERIOD_W-1:0] dcnt;  // remaining delay cycles
   logic [`MULADD_PERIOD_W-1:0] pcnt;  // position inside the group
   logic [`MULADD_ADDR_W-1:0]   icnt;  // groups finished so far
   logic                       last_p;
   logic                       last_i;

   assign last_p = (pcnt == cfg.cfg.period - `MULADD_PERIOD_W'd1);
   assign last_i = (icnt == cfg.cfg.iterations - `MULADD_ADDR_W'd1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= st_idle;
         dcnt  <= '0;
         pcnt  <= '0;
         icnt  <= '0;
      end else begin
         case (state)
            st_idle: begin
               pcnt <= '0;
               icnt <= '0;
               // zero iterations means nothing to do
               if (cfg.run && (cfg.cfg.iterations != '0)) begin
                  dcnt  <= cfg.cfg.delay;
                  state <= (cfg.cfg.delay != '0) ? st_delay : st_active;
               end
            end
            st_delay: begin
               dcnt <= dcnt - `MULADD_PERIOD_W'd1;
               if (dcnt == `MULADD_PERIOD_W'd1)
                  state <= st_active;
            end
            st_active: begin
               if (last_p) begin
                  pcnt <= '0;        // wrap back to start
                  icnt <= icnt + `MULADD_ADDR_W'd1;
                  if (last_i)
                     state <= st_idle;
               end else begin
                  pcnt <= pcnt + `MULADD_PERIOD_W'd1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   assign addr   = {{(`MULADD_ADDR_W-`MULADD_PERIOD_W){1'b0}}, pcnt};
   assign mem_en = (state == st_active);
   assign done   = (state == st_idle);  // also high out of reset

endmodule

`default_nettype wire

// ==== hdl/muladd_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface muladd_cfg_if;

   import muladd_cfg_pkg::*;

   muladd_cfg_t cfg;   // current settings
   logic        run;   // one cycle start strobe

   // register block side
   modport src (
      output cfg,
      output run
   );

   // consumers: address generator and datapath
   modport dst (
      input cfg,
      input run
   );

endinterface

`default_nettype wire

// ==== hdl/muladd_cfg_pkg.sv ====
`default_nettype none

`include "muladd_defs_defs.svh"

package muladd_cfg_pkg;

   // accumulate direction
   typedef enum logic {
      op_macc = 1'b0,
      op_msub = 1'b1
   } muladd_op_t;

   // full unit configuration, held by the register block
   typedef struct packed {
      muladd_op_t                 opcode;
      logic [`MULADD_ADDR_W-1:0]   iterations;  // groups per run
      logic [`MULADD_PERIOD_W-1:0] period;      // pairs per group
      logic [`MULADD_PERIOD_W-1:0] delay;       // idle cycles after run
      logic [`MULADD_SHIFT_W-1:0]  shift;       // logical right shift of result
   } muladd_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/muladd_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "muladd_defs_defs.svh"

module muladd_config_regs (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          cfg_we,
   input  wire logic [`MULADD_CFG_ADDR_W-1:0] cfg_addr,
   input  wire logic [`MULADD_ADDR_W-1:0]     cfg_wdata,
   muladd_cfg_if.src                          cfg
);

   import muladd_cfg_pkg::*;

   muladd_cfg_t cfg_q;
   logic        run_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg_q <= '0;
         run_q <= 1'b0;
      end else begin
         run_q <= cfg_we && (cfg_addr == `MULADD_REG_RUN); // high for one cycle only
         if (cfg_we) begin
            case (cfg_addr)
               `MULADD_REG_OPCODE: cfg_q.opcode     <= muladd_op_t'(cfg_wdata[0]);
               `MULADD_REG_ITER:   cfg_q.iterations <= cfg_wdata;
               `MULADD_REG_PERIOD: cfg_q.period     <= cfg_wdata[`MULADD_PERIOD_W-1:0];
               `MULADD_REG_DELAY:  cfg_q.delay      <= cfg_wdata[`MULADD_PERIOD_W-1:0];
               `MULADD_REG_SHIFT:  cfg_q.shift      <= cfg_wdata[`MULADD_SHIFT_W-1:0];
               default: ;          // run and unmapped addresses store nothing
            endcase
         end
      end
   end

   assign cfg.cfg = cfg_q;
   assign cfg.run = run_q;

endmodule

`default_nettype wire

// ==== hdl/muladd_data_pkg.sv ====
`default_nettype none

`include "muladd_defs_defs.svh"

package muladd_data_pkg;

   // operand and output word
   typedef logic signed [`MULADD_DATA_W-1:0] operand_t;

   // full precision product and group sum
   typedef logic signed [2*`MULADD_DATA_W-1:0] acc_t;

endpackage

`default_nettype wire

// ==== hdl/muladd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "muladd_defs_defs.svh"

module muladd_top (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          cfg_we,
   input  wire logic [`MULADD_CFG_ADDR_W-1:0] cfg_addr,
   input  wire logic [`MULADD_ADDR_W-1:0]     cfg_wdata,
   input  wire muladd_data_pkg::operand_t      in1,
   input  wire muladd_data_pkg::operand_t      in2,
   output muladd_data_pkg::operand_t          out,
   output logic                               out_valid,
   output logic                               done
);

   logic [`MULADD_ADDR_W-1:0] addr;
   logic                     mem_en;

   muladd_cfg_if cfg_bus ();

   muladd_config_regs u_config_regs (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg       (cfg_bus.src)
   );

   muladd_addr_gen u_addr_gen (
      .clk    (clk),
      .rst    (rst),
      .cfg    (cfg_bus.dst),
      .addr   (addr),
      .mem_en (mem_en),
      .done   (done)
   );

   muladd_unit u_unit (
      .clk       (clk),
      .rst       (rst),
      .cfg       (cfg_bus.dst),
      .in1       (in1),
      .in2       (in2),
      .addr      (addr),
      .mem_en    (mem_en),
      .out       (out),
      .out_valid (out_valid)
   );

endmodule

`default_nettype wire

// ==== hdl/muladd_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "muladd_defs_defs.svh"

module muladd_unit (
   input  wire logic                     clk,
   input  wire logic                     rst,
   muladd_cfg_if.dst                     cfg,
   input  wire muladd_data_pkg::operand_t in1,
   input  wire muladd_data_pkg::operand_t in2,
   input  wire logic [`MULADD_ADDR_W-1:0] addr,
   input  wire logic                     mem_en,
   output muladd_data_pkg::operand_t     out,
   output logic                          out_valid
);

   import muladd_cfg_pkg::*;
   import muladd_data_pkg::*;

   operand_t                   in1_q;
   operand_t                   in2_q;
   acc_t                       prod;
   acc_t                       acc;
   acc_t                       acc_base;
   acc_t                       out_q;
   acc_t                       shifted;
   logic                       restart1;
   logic                       restart2;
   logic [`MULADD_LATENCY:0]    last_pipe;  // last flag, one bit per stage
   logic [`MULADD_ADDR_W-1:0]   last_addr;

   assign last_addr = `MULADD_ADDR_W'(cfg.cfg.period) - `MULADD_ADDR_W'd1;

   // control flags travel beside the data
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         restart1  <= 1'b0;
         restart2  <= 1'b0;
         last_pipe <= '0;
      end else begin
         restart1  <= (addr == '0);
         restart2  <= restart1;
         last_pipe <= {last_pipe[`MULADD_LATENCY-1:0], mem_en && (addr == last_addr)};
      end
   end

   assign acc_base = restart2 ? '0 : acc;  // new group starts from zero

   // dsp style datapath, no reset on payload
   always_ff @(posedge clk) begin
      in1_q <= in1;                  // stage 1
      in2_q <= in2;
      prod  <= in1_q * in2_q;        // stage 2, full width signed
      if (cfg.cfg.opcode == op_macc) // stage 3
         acc <= acc_base + prod;
      else
         acc <= acc_base - prod;
      out_q <= acc;                  // output register
   end

   assign shifted   = out_q >> cfg.cfg.shift;   // logical shift
   assign out       = shifted[`MULADD_DATA_W-1:0];
   assign out_valid = last_pipe[`MULADD_LATENCY];

endmodule

`default_nettype wire

// ==== include/muladd_defs_defs.svh ====
`ifndef MULADD_DEFS_DEFS_SVH
`define MULADD_DEFS_DEFS_SVH

// datapath widths
`define MULADD_DATA_W    16   // operands and output
`define MULADD_ADDR_W    10   // iteration counter and address
`define MULADD_PERIOD_W  5    // period and delay
`define MULADD_SHIFT_W   5    // output shift amount

// edges from operand sample to out_valid
`define MULADD_LATENCY   3

// config register map
`define MULADD_CFG_ADDR_W  3
`define MULADD_REG_OPCODE  3'd0
`define MULADD_REG_ITER    3'd1
`define MULADD_REG_PERIOD  3'd2
`define MULADD_REG_DELAY   3'd3
`define MULADD_REG_SHIFT   3'd4
`define MULADD_REG_RUN     3'd5   // write only, fires the run pulse

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the muladd testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_muladd -f verilog.f -o tb_muladd \
   && ./obj_dir/tb_muladd > sim.log 2>&1 \
   ; cat sim.log 2>/dev/null \
   ; grep -q "^Test OK$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== tb/muladd_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "muladd_defs_defs.svh"

module muladd_checker (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire muladd_data_pkg::operand_t   in1,
   input  wire muladd_data_pkg::operand_t   in2,
   input  wire muladd_data_pkg::operand_t   out,
   input  wire logic                        out_valid,
   input  wire logic                        done,
   input  wire logic                        pair_valid,  // a pair is on in1/in2 for the unit
   input  wire logic                        exp_msub,
   input  wire logic [`MULADD_PERIOD_W-1:0] exp_period,
   input  wire logic [`MULADD_SHIFT_W-1:0]  exp_shift,
   input  wire logic [8*16-1:0]             test_name,
   output int                               errors,
   output int                               pending,
   output int                               valid_count
);

   import muladd_data_pkg::*;

   operand_t        grp_a[$];   // pairs of the group being collected
   operand_t        grp_b[$];
   operand_t        exp_q[$];   // results still to come out of the unit
   logic [8*16-1:0] name_q[$];
   operand_t        exp_val;
   logic [8*16-1:0] exp_name;
   int              err_cnt = 0;
   int              pend_cnt = 0;
   int              vld_cnt = 0;

   // expected output of one finished group
   function automatic operand_t group_result(input logic msub,
                                             input logic [`MULADD_SHIFT_W-1:0] shift);
      longint                      sum;
      longint                      pa;
      longint                      pb;
      logic [2*`MULADD_DATA_W-1:0] wide;
      int                          i;
      sum = 0;
      for (i = 0; i < grp_a.size(); i++) begin
         pa  = longint'(grp_a[i]);   // sign extended
         pb  = longint'(grp_b[i]);
         sum = sum + pa * pb;
      end
      if (msub)
         sum = -sum;
      wide = sum[2*`MULADD_DATA_W-1:0];  // accumulator width wraps
      wide = wide >> shift;              // logical, zeros come in
      return wide[`MULADD_DATA_W-1:0];
   endfunction

   always @(posedge clk) begin
      if (!rst) begin
         if (out_valid) begin
            vld_cnt = vld_cnt + 1;
            if (exp_q.size() == 0) begin
               err_cnt = err_cnt + 1;
               $display("out_valid came with no result expected in test %0s", test_name);
            end else begin
               exp_val  = exp_q.pop_front();
               exp_name = name_q.pop_front();
               if (out !== exp_val) begin
                  err_cnt = err_cnt + 1;
                  $display("Error: test %0s expected %h actual %h", exp_name, exp_val, out);
               end
            end
         end
         if (pair_valid) begin
            if (done !== 1'b0) begin
               err_cnt = err_cnt + 1;
               $display("done was high while operands were accepted in test %0s", test_name);
            end
            grp_a.push_back(in1);
            grp_b.push_back(in2);
            if (grp_a.size() == int'(exp_period)) begin  // group complete
               exp_q.push_back(group_result(exp_msub, exp_shift));
               name_q.push_back(test_name);
               grp_a.delete();
               grp_b.delete();
            end
         end
         pend_cnt = exp_q.size();
      end
   end

   assign errors      = err_cnt;
   assign pending     = pend_cnt;
   assign valid_count = vld_cnt;

endmodule

`default_nettype wire

// ==== tb/tb_muladd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "muladd_defs_defs.svh"

module tb_muladd;

   import muladd_data_pkg::*;

   localparam int unsigned SEED       = 32'h3900a53f;
   localparam int          WAIT_LIMIT = 200;   // cycles per wait

   logic                          clk;
   logic                          rst;
   logic                          cfg_we;
   logic [`MULADD_CFG_ADDR_W-1:0] cfg_addr;
   logic [`MULADD_ADDR_W-1:0]     cfg_wdata;
   operand_t                      in1;
   operand_t                      in2;
   operand_t                      out;
   logic                          out_valid;
   logic                          done;

   logic                          pair_valid;
   logic                          exp_msub;
   logic [`MULADD_PERIOD_W-1:0]   exp_period;
   logic [`MULADD_SHIFT_W-1:0]    exp_shift;
   logic [8*16-1:0]               test_name;
   int                            chk_errors;
   int                            pending;
   int                            valid_count;
   int                            tb_errors = 0;

   muladd_top dut (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .in1       (in1),
      .in2       (in2),
      .out       (out),
      .out_valid (out_valid),
      .done      (done)
   );

   muladd_checker chk (
      .clk         (clk),
      .rst         (rst),
      .in1         (in1),
      .in2         (in2),
      .out         (out),
      .out_valid   (out_valid),
      .done        (done),
      .pair_valid  (pair_valid),
      .exp_msub    (exp_msub),
      .exp_period  (exp_period),
      .exp_shift   (exp_shift),
      .test_name   (test_name),
      .errors      (chk_errors),
      .pending     (pending),
      .valid_count (valid_count)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic operand_t rand_operand(input int big);
      logic [31:0] r;
      r = $urandom();
      if (big != 0)
         return {r[15], ~r[15], r[13:0]};  // magnitude at least 2**14
      return {{7{r[8]}}, r[8:0]};         // small, -256 to 255
   endfunction

   task automatic write_reg(input logic [`MULADD_CFG_ADDR_W-1:0] a, input int d);
      @(posedge clk);
      cfg_we    <= 1'b1;
      cfg_addr  <= a;
      cfg_wdata <= d[`MULADD_ADDR_W-1:0];
   endtask

   task automatic check_count(input int expected, input int actual);
      if (expected != actual) begin
         tb_errors = tb_errors + 1;
         $display("Error: test %0s expected %0d actual %0d", test_name, expected, actual);
      end
   endtask

   // done and out_valid must stay quiet for the whole window
   task automatic check_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         if (done !== 1'b1 || out_valid !== 1'b0) begin
            tb_errors = tb_errors + 1;
            $display("unit was not idle in test %0s", test_name);
         end
      end
   endtask

   task automatic wait_done();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (done !== 1'b1 && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (done !== 1'b1) begin
         tb_errors = tb_errors + 1;
         $display("timed out waiting for done in test %0s", test_name);
      end
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (pending != 0 && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (pending != 0) begin
         tb_errors = tb_errors + 1;
         $display("timed out waiting for %0d results in test %0s", pending, test_name);
      end
   endtask

   task automatic run_test(input logic [8*16-1:0] name, input int msub, input int iter,
                           input int period, input int delay, input int shift,
                           input int big);
      int base;
      int i;
      base = valid_count;
      write_reg(`MULADD_REG_OPCODE, msub);
      exp_msub   <= (msub != 0);
      exp_period <= `MULADD_PERIOD_W'(period);
      exp_shift  <= `MULADD_SHIFT_W'(shift);
      test_name  <= name;
      write_reg(`MULADD_REG_ITER, iter);
      write_reg(`MULADD_REG_PERIOD, period);
      write_reg(`MULADD_REG_DELAY, delay);
      write_reg(`MULADD_REG_SHIFT, shift);
      write_reg(`MULADD_REG_RUN, 0);
      @(posedge clk);
      cfg_we <= 1'b0;
      repeat (delay + 1) @(posedge clk);   // first active cycle of the generator
      for (i = 0; i < iter * period; i++) begin
         in1        <= rand_operand(big);
         in2        <= rand_operand(big);
         pair_valid <= 1'b1;
         @(posedge clk);
      end
      pair_valid <= 1'b0;
      wait_done();
      wait_drain();
      check_count(iter, valid_count - base);   // one out_valid per group
   endtask

   initial begin
      rst        = 1'b1;
      cfg_we     = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      in1        = '0;
      in2        = '0;
      pair_valid = 1'b0;
      exp_msub   = 1'b0;
      exp_period = '0;
      exp_shift  = '0;
      test_name  = "reset";
      void'($urandom(SEED));
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      check_idle(10);
      check_count(0, valid_count);

      run_test("macc_p4", 0, 3, 4, 0, 0, 0);
      run_test("msub_p5", 1, 2, 5, 0, 0, 1);
      run_test("shift8", 0, 3, 4, 0, 8, 1);
      run_test("delay6", 0, 8, 1, 6, 0, 0);
      run_test("iter0", 0, 0, 4, 3, 0, 0);   // run must be ignored
      check_idle(20);

      $display("errors: %0d in compares, %0d in other checks", chk_errors, tb_errors);
      if (chk_errors == 0 && tb_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
hdl/muladd_cfg_pkg.sv
hdl/muladd_data_pkg.sv
hdl/muladd_cfg_if.sv
hdl/muladd_config_regs.sv
hdl/muladd_addr_gen.sv
hdl/muladd_unit.sv
hdl/muladd_top.sv
tb/muladd_checker.sv
tb/tb_muladd.sv
